//--- verilog/pmp_pkg.sv
package pmp_pkg;

  // Region count and index width
  localparam int NUM_REGIONS  = 4;
  localparam int REGION_IDX_W = 2;

  // Register map, byte offsets of word registers
  localparam logic [7:0] ADDR_PMPCFG0  = 8'h00;
  localparam logic [7:0] ADDR_PMPADDR0 = 8'h40;
  localparam logic [7:0] ADDR_MSECCFG  = 8'h80;

  // Rule-locking bypass position in mseccfg
  localparam int MSECCFG_RLB_BIT = 2;

  // Address-matching mode of one region
  typedef enum logic [1:0] {
    MODE_OFF   = 2'd0,
    MODE_TOR   = 2'd1,
    MODE_NA4   = 2'd2,
    MODE_NAPOT = 2'd3
  } pmp_mode_e;

  // One config byte as seen in pmpcfg
  typedef struct packed {
    logic       lock;
    logic [1:0] zero;
    pmp_mode_e  mode;
    logic       exec;
    logic       write;
    logic       read;
  } pmp_cfg_t;

  // pmpcfg0, either the raw bus word or four config bytes
  // Region 0 sits in the lowest byte
  typedef union packed {
    logic [31:0]                raw;
    pmp_cfg_t [NUM_REGIONS-1:0] cfg;
  } pmp_cfg_word_u;

  // Access type of a check request
  typedef enum logic [1:0] {
    ACC_EXEC  = 2'd0,
    ACC_READ  = 2'd1,
    ACC_WRITE = 2'd2
  } pmp_acc_e;

  // Effective privilege, as in mstatus.MPP
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } pmp_priv_e;

  // Register select between bus slave and register file
  // The pmpaddr codes are consecutive so an index can be added to REG_ADDR0
  typedef enum logic [2:0] {
    REG_NONE    = 3'd0,
    REG_CFG0    = 3'd1,
    REG_MSECCFG = 3'd2,
    REG_ADDR0   = 3'd4,
    REG_ADDR1   = 3'd5,
    REG_ADDR2   = 3'd6,
    REG_ADDR3   = 3'd7
  } pmp_reg_sel_e;

endpackage

//--- verilog/pmp_region_match.sv
`timescale 1ns/10ps

module pmp_region_match (
  input  pmp_pkg::pmp_mode_e  mode_i,
  input  logic [31:0]         addr_i,
  input  logic [31:0]         pmpaddr_i,
  input  logic [31:0]         pmpaddr_below_i,
  output logic                match_o
);

  logic [33:0]  addr_ext;
  logic [31:0]  addr_word;
  logic [31:0]  napot_mask;
  logic         tor_hit;
  logic         na4_hit;
  logic         napot_hit;

  // pmpaddr holds bits 33:2 of a 34-bit physical address
  assign addr_ext  = {2'b00, addr_i};
  assign addr_word = addr_ext[33:2];

  assign tor_hit = ({pmpaddr_below_i, 2'b00} <= addr_ext) &&
                   (addr_ext < {pmpaddr_i, 2'b00});

  assign na4_hit = (addr_i[31:2] == pmpaddr_i[29:0]);

  // Trailing ones plus the zero above them flip on increment
  // and mark the bits that do not take part in the compare
  assign napot_mask = ~(pmpaddr_i ^ (pmpaddr_i + 32'd1));
  assign napot_hit  = ((addr_word & napot_mask) == (pmpaddr_i & napot_mask));

  always_comb begin
    case (mode_i)
      pmp_pkg::MODE_TOR:   match_o = tor_hit;
      pmp_pkg::MODE_NA4:   match_o = na4_hit;
      pmp_pkg::MODE_NAPOT: match_o = napot_hit;
      default:             match_o = 1'b0;
    endcase
  end

endmodule

//--- verilog/pmp_cfg_legalize.sv
`timescale 1ns/10ps

module pmp_cfg_legalize (
  input  pmp_pkg::pmp_cfg_t  cfg_prev_i,
  input  pmp_pkg::pmp_cfg_t  cfg_attempt_i,
  input  logic               rlb_i,
  output pmp_pkg::pmp_cfg_t  cfg_legal_o
);

  pmp_pkg::pmp_cfg_t  cfg_legal;
  logic               rwx_reserved;
  logic               entry_locked;

  // Write without read is a reserved RWX combination
  assign rwx_reserved = cfg_attempt_i.write && !cfg_attempt_i.read;

  // Lock holds unless the bypass is set
  assign entry_locked = cfg_prev_i.lock && !rlb_i;

  always_comb begin
    cfg_legal = cfg_attempt_i;

    if (rwx_reserved) begin
      cfg_legal.exec  = cfg_prev_i.exec;
      cfg_legal.write = cfg_prev_i.write;
      cfg_legal.read  = cfg_prev_i.read;
    end

    // Whole byte frozen while locked
    if (entry_locked) begin
      cfg_legal = cfg_prev_i;
    end

    cfg_legal.zero = '0;
  end

  assign cfg_legal_o = cfg_legal;

endmodule

//--- verilog/pmp_check_fsm.sv
`timescale 1ns/10ps

module pmp_check_fsm (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,

  input  logic                                   chk_req_i,
  input  logic [31:0]                            chk_addr_i,
  input  pmp_pkg::pmp_acc_e                      chk_acc_i,
  input  pmp_pkg::pmp_priv_e                     chk_priv_i,

  input  pmp_pkg::pmp_cfg_word_u                 cfg_i,
  input  logic [pmp_pkg::NUM_REGIONS-1:0][31:0]  addr_i,

  output logic                                   chk_done_o,
  output logic                                   chk_allow_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SCAN,
    ST_DONE
  } state_e;

  state_e                            state_q;
  state_e                            state_d;
  logic [pmp_pkg::REGION_IDX_W-1:0]  idx_q;
  logic [31:0]                       addr_q;
  pmp_pkg::pmp_acc_e                 acc_q;
  pmp_pkg::pmp_priv_e                priv_q;
  pmp_pkg::pmp_cfg_t                 cur_cfg;
  logic [31:0]                       bound_below;
  logic                              region_hit;
  logic                              last_region;
  logic                              scan_end;
  logic                              perm;
  logic                              allow_d;
  logic                              allow_q;

  assign cur_cfg     = cfg_i.cfg[idx_q];
  // Region 0 is bounded below by address zero
  assign bound_below = (idx_q == '0) ? '0 : addr_i[idx_q - 1'b1];

  pmp_region_match u_region_match (
    .mode_i          (cur_cfg.mode),
    .addr_i          (addr_q),
    .pmpaddr_i       (addr_i[idx_q]),
    .pmpaddr_below_i (bound_below),
    .match_o         (region_hit)
  );

  assign last_region = (idx_q == pmp_pkg::REGION_IDX_W'(pmp_pkg::NUM_REGIONS - 1));
  assign scan_end    = region_hit || last_region;

  always_comb begin
    case (acc_q)
      pmp_pkg::ACC_EXEC:  perm = cur_cfg.exec;
      pmp_pkg::ACC_READ:  perm = cur_cfg.read;
      pmp_pkg::ACC_WRITE: perm = cur_cfg.write;
      default:            perm = 1'b0;
    endcase
    // M-mode passes unlocked regions and any access that hits nothing
    if (region_hit) begin
      allow_d = perm || ((priv_q == pmp_pkg::PRIV_M) && !cur_cfg.lock);
    end else begin
      allow_d = (priv_q == pmp_pkg::PRIV_M);
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: if (chk_req_i) state_d = ST_SCAN;
      ST_SCAN: if (scan_end) state_d = ST_DONE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      idx_q   <= '0;
      allow_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == ST_IDLE) begin
        idx_q <= '0;
      end else if (state_q == ST_SCAN) begin
        if (scan_end) allow_q <= allow_d;
        else idx_q <= idx_q + 1'b1;
      end
    end
  end

  // Request held steady by the requester, captured once
  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && chk_req_i) begin
      addr_q <= chk_addr_i;
      acc_q  <= chk_acc_i;
      priv_q <= chk_priv_i;
    end
  end

  assign chk_done_o  = (state_q == ST_DONE);
  assign chk_allow_o = allow_q;

endmodule

//--- verilog/pmp_csr_regs.sv
`timescale 1ns/10ps

module pmp_csr_regs (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,

  input  logic                                   wr_en_i,
  input  pmp_pkg::pmp_reg_sel_e                  wr_sel_i,
  input  logic [31:0]                            wr_data_i,

  output pmp_pkg::pmp_cfg_word_u                 cfg_o,
  output logic [pmp_pkg::NUM_REGIONS-1:0][31:0]  addr_o,
  output logic                                   rlb_o
);

  pmp_pkg::pmp_cfg_word_u                  cfg_q;
  pmp_pkg::pmp_cfg_word_u                  wr_word;
  pmp_pkg::pmp_cfg_t                       cfg_legal [pmp_pkg::NUM_REGIONS];
  logic [pmp_pkg::NUM_REGIONS-1:0][31:0]   addr_q;
  logic [pmp_pkg::NUM_REGIONS-1:0]         addr_locked;
  logic                                    rlb_q;
  logic                                    any_locked;
  logic                                    rlb_set_blocked;

  // Bus word split into the four attempted config bytes
  assign wr_word.raw = wr_data_i;

  for (genvar i = 0; i < pmp_pkg::NUM_REGIONS; i++) begin : gen_region
    pmp_cfg_legalize u_cfg_legalize (
      .cfg_prev_i    (cfg_q.cfg[i]),
      .cfg_attempt_i (wr_word.cfg[i]),
      .rlb_i         (rlb_q),
      .cfg_legal_o   (cfg_legal[i])
    );

    // pmpaddr i is also the lower bound of a TOR entry i+1
    if (i < pmp_pkg::NUM_REGIONS - 1) begin : gen_below
      assign addr_locked[i] = !rlb_q &&
                              (cfg_q.cfg[i].lock ||
                               (cfg_q.cfg[i+1].lock &&
                                (cfg_q.cfg[i+1].mode == pmp_pkg::MODE_TOR)));
    end else begin : gen_top
      assign addr_locked[i] = !rlb_q && cfg_q.cfg[i].lock;
    end
  end

  always_comb begin
    any_locked = 1'b0;
    for (int i = 0; i < pmp_pkg::NUM_REGIONS; i++) begin
      any_locked = any_locked | cfg_q.cfg[i].lock;
    end
  end

  // RLB cannot be raised once an entry is locked without it
  assign rlb_set_blocked = wr_data_i[pmp_pkg::MSECCFG_RLB_BIT] && !rlb_q && any_locked;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q  <= '0;
      addr_q <= '0;
      rlb_q  <= 1'b0;
    end else if (wr_en_i) begin
      case (wr_sel_i)
        pmp_pkg::REG_CFG0: begin
          for (int i = 0; i < pmp_pkg::NUM_REGIONS; i++) begin
            cfg_q.cfg[i] <= cfg_legal[i];
          end
        end
        pmp_pkg::REG_MSECCFG: begin
          if (!rlb_set_blocked) rlb_q <= wr_data_i[pmp_pkg::MSECCFG_RLB_BIT];
        end
        default: begin
          for (int i = 0; i < pmp_pkg::NUM_REGIONS; i++) begin
            if ((wr_sel_i == pmp_pkg::REG_ADDR0 + i) && !addr_locked[i]) begin
              addr_q[i] <= wr_data_i;
            end
          end
        end
      endcase
    end
  end

  assign cfg_o  = cfg_q;
  assign addr_o = addr_q;
  assign rlb_o  = rlb_q;

endmodule

//--- verilog/pmp_csr_bus.sv
`timescale 1ns/10ps

module pmp_csr_bus (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,

  input  logic                                   wb_cyc_i,
  input  logic                                   wb_stb_i,
  input  logic                                   wb_we_i,
  input  logic [7:0]                             wb_adr_i,
  input  logic [31:0]                            wb_dat_i,
  output logic [31:0]                            wb_dat_o,
  output logic                                   wb_ack_o,

  // Write strobe towards the register file
  output logic                                   wr_en_o,
  output pmp_pkg::pmp_reg_sel_e                  wr_sel_o,
  output logic [31:0]                            wr_data_o,

  // Current register values for read-back
  input  pmp_pkg::pmp_cfg_word_u                 cfg_i,
  input  logic [pmp_pkg::NUM_REGIONS-1:0][31:0]  addr_i,
  input  logic                                   rlb_i
);

  typedef enum logic {
    ST_IDLE,
    ST_ACK
  } state_e;

  state_e                              state_q;
  pmp_pkg::pmp_reg_sel_e               sel;
  logic [pmp_pkg::REGION_IDX_W-1:0]    addr_idx;
  logic [31:0]                         rdata;

  // One ack cycle per bus cycle, master drops stb afterwards
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: if (wb_cyc_i && wb_stb_i) state_q <= ST_ACK;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Address decode, anything off the map selects nothing
  always_comb begin
    sel = pmp_pkg::REG_NONE;
    if (wb_adr_i == pmp_pkg::ADDR_PMPCFG0) begin
      sel = pmp_pkg::REG_CFG0;
    end else if (wb_adr_i == pmp_pkg::ADDR_MSECCFG) begin
      sel = pmp_pkg::REG_MSECCFG;
    end else begin
      for (int i = 0; i < pmp_pkg::NUM_REGIONS; i++) begin
        if (wb_adr_i == pmp_pkg::ADDR_PMPADDR0 + 8'(4 * i)) begin
          sel = pmp_pkg::pmp_reg_sel_e'(pmp_pkg::REG_ADDR0 + i);
        end
      end
    end
  end

  assign addr_idx = wb_adr_i[2 +: pmp_pkg::REGION_IDX_W];

  // Read multiplexer
  always_comb begin
    rdata = '0;
    case (sel)
      pmp_pkg::REG_CFG0:    rdata = cfg_i.raw;
      pmp_pkg::REG_MSECCFG: rdata[pmp_pkg::MSECCFG_RLB_BIT] = rlb_i;
      pmp_pkg::REG_ADDR0,
      pmp_pkg::REG_ADDR1,
      pmp_pkg::REG_ADDR2,
      pmp_pkg::REG_ADDR3:   rdata = addr_i[addr_idx];
      default:              rdata = '0;
    endcase
  end

  assign wb_ack_o = (state_q == ST_ACK);
  assign wb_dat_o = rdata;

  // Write lands on the edge that closes the ack cycle
  assign wr_en_o   = (state_q == ST_ACK) && wb_we_i && (sel != pmp_pkg::REG_NONE);
  assign wr_sel_o  = sel;
  assign wr_data_o = wb_dat_i;

endmodule

//--- verilog/pmp_top.sv
`timescale 1ns/10ps

module pmp_top (
  input  logic                clk_i,
  input  logic                rst_ni,

  // Wishbone classic slave
  input  logic                wb_cyc_i,
  input  logic                wb_stb_i,
  input  logic                wb_we_i,
  input  logic [7:0]          wb_adr_i,
  input  logic [31:0]         wb_dat_i,
  output logic [31:0]         wb_dat_o,
  output logic                wb_ack_o,

  // Access check request
  input  logic                chk_req_i,
  input  logic [31:0]         chk_addr_i,
  input  pmp_pkg::pmp_acc_e   chk_acc_i,
  input  pmp_pkg::pmp_priv_e  chk_priv_i,
  output logic                chk_done_o,
  output logic                chk_allow_o
);

  logic                                     wr_en;
  pmp_pkg::pmp_reg_sel_e                    wr_sel;
  logic [31:0]                              wr_data;
  pmp_pkg::pmp_cfg_word_u                   cfg;
  logic [pmp_pkg::NUM_REGIONS-1:0][31:0]    pmpaddr;
  logic                                     rlb;

  pmp_csr_bus u_csr_bus (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_we_i   (wb_we_i),
    .wb_adr_i  (wb_adr_i),
    .wb_dat_i  (wb_dat_i),
    .wb_dat_o  (wb_dat_o),
    .wb_ack_o  (wb_ack_o),
    .wr_en_o   (wr_en),
    .wr_sel_o  (wr_sel),
    .wr_data_o (wr_data),
    .cfg_i     (cfg),
    .addr_i    (pmpaddr),
    .rlb_i     (rlb)
  );

  pmp_csr_regs u_csr_regs (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .wr_en_i   (wr_en),
    .wr_sel_i  (wr_sel),
    .wr_data_i (wr_data),
    .cfg_o     (cfg),
    .addr_o    (pmpaddr),
    .rlb_o     (rlb)
  );

  pmp_check_fsm u_check_fsm (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .chk_req_i   (chk_req_i),
    .chk_addr_i  (chk_addr_i),
    .chk_acc_i   (chk_acc_i),
    .chk_priv_i  (chk_priv_i),
    .cfg_i       (cfg),
    .addr_i      (pmpaddr),
    .chk_done_o  (chk_done_o),
    .chk_allow_o (chk_allow_o)
  );

endmodule

//--- test/pmp_props.sv
`timescale 1ns/10ps

module pmp_props (
  input logic clk_i,
  input logic rst_ni,
  input logic wb_cyc_i,
  input logic wb_stb_i,
  input logic wb_ack_o,
  input logic chk_done_o
);

  // Ack lasts exactly one cycle
  ack_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_ack_o |=> !wb_ack_o)
    else $error("wb_ack_o stayed high for two cycles");

  // No ack outside a bus cycle
  ack_in_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_ack_o |-> (wb_cyc_i && wb_stb_i))
    else $error("wb_ack_o high without cyc and stb");

  // Done is a single pulse per check
  done_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    chk_done_o |=> !chk_done_o)
    else $error("chk_done_o stayed high for two cycles");

endmodule

bind pmp_top pmp_props u_pmp_props (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .wb_cyc_i   (wb_cyc_i),
  .wb_stb_i   (wb_stb_i),
  .wb_ack_o   (wb_ack_o),
  .chk_done_o (chk_done_o)
);

//--- test/tb_pmp.sv
`timescale 1ns/10ps

module tb_pmp;

  logic                clk_i;
  logic                rst_ni;
  logic                wb_cyc_i;
  logic                wb_stb_i;
  logic                wb_we_i;
  logic [7:0]          wb_adr_i;
  logic [31:0]         wb_dat_i;
  logic [31:0]         wb_dat_o;
  logic                wb_ack_o;
  logic                chk_req_i;
  logic [31:0]         chk_addr_i;
  pmp_pkg::pmp_acc_e   chk_acc_i;
  pmp_pkg::pmp_priv_e  chk_priv_i;
  logic                chk_done_o;
  logic                chk_allow_o;

  logic [31:0]  lcg_state;
  // Reference register state
  logic [7:0]   m_cfg [4];
  logic [31:0]  m_addr [4];
  logic         m_rlb;
  int           errors;
  int           tests_run;
  int           tests_failed;

  pmp_top u_pmp_top (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .chk_req_i   (chk_req_i),
    .chk_addr_i  (chk_addr_i),
    .chk_acc_i   (chk_acc_i),
    .chk_priv_i  (chk_priv_i),
    .chk_done_o  (chk_done_o),
    .chk_allow_o (chk_allow_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic [31:0] rand32();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [7:0] addr_of(input int i);
    return pmp_pkg::ADDR_PMPADDR0 + 8'(4 * i);
  endfunction

  function automatic logic is_mapped(input logic [7:0] adr);
    logic hit;
    hit = (adr == pmp_pkg::ADDR_PMPCFG0) || (adr == pmp_pkg::ADDR_MSECCFG);
    for (int i = 0; i < 4; i++) begin
      if (adr == addr_of(i)) hit = 1'b1;
    end
    return hit;
  endfunction

  function automatic logic [31:0] model_read(input logic [7:0] adr);
    logic [31:0] v;
    v = '0;
    if (adr == pmp_pkg::ADDR_PMPCFG0) v = {m_cfg[3], m_cfg[2], m_cfg[1], m_cfg[0]};
    if (adr == pmp_pkg::ADDR_MSECCFG) v[pmp_pkg::MSECCFG_RLB_BIT] = m_rlb;
    for (int i = 0; i < 4; i++) begin
      if (adr == addr_of(i)) v = m_addr[i];
    end
    return v;
  endfunction

  // Stored value of one config byte after a write attempt
  function automatic logic [7:0] legal_cfg(input logic [7:0] prev, input logic [7:0] att);
    logic [7:0] res;
    if (prev[7] && !m_rlb) return prev;
    res = att;
    // Write without read keeps the old permissions
    if (att[1] && !att[0]) res[2:0] = prev[2:0];
    res[6:5] = 2'b00;
    return res;
  endfunction

  task automatic model_write(input logic [7:0] adr, input logic [31:0] data);
    logic any_lock;
    logic blocked;
    any_lock = m_cfg[0][7] | m_cfg[1][7] | m_cfg[2][7] | m_cfg[3][7];
    if (adr == pmp_pkg::ADDR_PMPCFG0) begin
      for (int i = 0; i < 4; i++) m_cfg[i] = legal_cfg(m_cfg[i], data[8*i +: 8]);
    end else if (adr == pmp_pkg::ADDR_MSECCFG) begin
      if (!(data[pmp_pkg::MSECCFG_RLB_BIT] && !m_rlb && any_lock)) begin
        m_rlb = data[pmp_pkg::MSECCFG_RLB_BIT];
      end
    end
    for (int i = 0; i < 4; i++) begin
      blocked = m_cfg[i][7];
      if (i < 3) begin
        if (m_cfg[i+1][7] && m_cfg[i+1][4:3] == 2'd1) blocked = 1'b1;
      end
      if (adr == addr_of(i) && !(blocked && !m_rlb)) m_addr[i] = data;
    end
  endtask

  function automatic logic region_hits(input int i, input logic [31:0] a);
    logic [33:0] a34;
    logic [33:0] lo;
    int          ones;
    a34 = {2'b00, a};
    lo = '0;
    if (i > 0) lo = {m_addr[i-1], 2'b00};
    ones = 0;
    while (ones < 32 && m_addr[i][ones]) ones++;
    case (m_cfg[i][4:3])
      2'd1:    return (lo <= a34) && (a34 < {m_addr[i], 2'b00});
      2'd2:    return a[31:2] == m_addr[i][29:0];
      2'd3:    return (a34 >> (ones + 3)) == ({m_addr[i], 2'b00} >> (ones + 3));
      default: return 1'b0;
    endcase
  endfunction

  // First matching region decides, no match leaves only M-mode
  function automatic logic model_allow(input logic [31:0] a, input logic [1:0] acc,
                                       input logic m_mode);
    logic perm;
    for (int i = 0; i < 4; i++) begin
      if (region_hits(i, a)) begin
        perm = (acc == 2'd0) ? m_cfg[i][2] : (acc == 2'd1) ? m_cfg[i][0] : m_cfg[i][1];
        return perm || (m_mode && !m_cfg[i][7]);
      end
    end
    return m_mode;
  endfunction

  task automatic apply_reset();
    @(negedge clk_i);
    rst_ni = 1'b0;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    for (int i = 0; i < 4; i++) begin
      m_cfg[i] = '0;
      m_addr[i] = '0;
    end
    m_rlb = 1'b0;
  endtask

  task automatic bus_xfer(input logic we, input logic [7:0] adr, input logic [31:0] wdata,
                          output logic [31:0] rdata);
    int   waited;
    logic got;
    @(negedge clk_i);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = wdata;
    got = 1'b0;
    waited = 0;
    rdata = '0;
    while (!got && waited < 16) begin
      @(negedge clk_i);
      waited++;
      if (wb_ack_o) begin
        got = 1'b1;
        rdata = wb_dat_o;
      end
    end
    assert (got) else begin
      $display("Bus slave never acknowledged the access to address %h", adr);
      errors++;
    end
    // Held through the ack cycle so the write lands on its closing edge
    @(negedge clk_i);
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic reg_write(input logic [7:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    model_write(adr, data);
    bus_xfer(1'b1, adr, data, unused);
  endtask

  task automatic reg_expect(input logic [7:0] adr);
    logic [31:0] rd;
    logic [31:0] exp;
    exp = model_read(adr);
    bus_xfer(1'b0, adr, '0, rd);
    assert (rd === exp) else begin
      $display("MISMATCH at %0t: read of %h gave %h, expected %h", $time, adr, rd, exp);
      errors++;
    end
  endtask

  task automatic check_access(input logic [31:0] a, input logic [1:0] acc, input logic m_mode);
    int   waited;
    logic done;
    logic allow;
    logic exp;
    exp = model_allow(a, acc, m_mode);
    @(negedge clk_i);
    chk_req_i  = 1'b1;
    chk_addr_i = a;
    chk_acc_i  = pmp_pkg::pmp_acc_e'(acc);
    chk_priv_i = m_mode ? pmp_pkg::PRIV_M : pmp_pkg::PRIV_U;
    done = 1'b0;
    allow = 1'b0;
    waited = 0;
    while (!done && waited < 16) begin
      @(negedge clk_i);
      waited++;
      if (chk_done_o) begin
        done = 1'b1;
        allow = chk_allow_o;
      end
    end
    chk_req_i = 1'b0;
    assert (done) else begin
      $display("Access checker never raised done for address %h", a);
      errors++;
    end
    assert (!done || allow === exp) else begin
      $display("MISMATCH at %0t: check of %h acc %0d m_mode %0b gave allow %0b, expected %0b",
               $time, a, acc, m_mode, allow, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int base);
    tests_run++;
    if (errors > base) tests_failed++;
    $display("test %-14s %s (%0d errors)", name, (errors > base) ? "FAIL" : "PASS",
             errors - base);
  endtask

  initial begin
    int          base;
    logic [31:0] r;
    logic [31:0] a;
    rst_ni = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    chk_req_i = 1'b0;
    chk_addr_i = '0;
    chk_acc_i = pmp_pkg::ACC_READ;
    chk_priv_i = pmp_pkg::PRIV_M;
    lcg_state = 32'h585f4ec8;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;

    // Random cfg words with lock bits clear so every write lands
    base = errors;
    apply_reset();
    repeat (40) begin
      reg_write(pmp_pkg::ADDR_PMPCFG0, rand32() & 32'h7f7f7f7f);
      reg_expect(pmp_pkg::ADDR_PMPCFG0);
    end
    report_test("legalize", base);

    // Entry 1 locked NA4, entry 3 locked TOR over pmpaddr2
    base = errors;
    apply_reset();
    for (int i = 0; i < 4; i++) reg_write(addr_of(i), rand32());
    reg_write(pmp_pkg::ADDR_PMPCFG0, 32'h8B009100);
    repeat (3) begin
      reg_write(pmp_pkg::ADDR_PMPCFG0, rand32() & 32'hff7fff7f);
      for (int i = 0; i < 4; i++) reg_write(addr_of(i), rand32());
      reg_expect(pmp_pkg::ADDR_PMPCFG0);
      for (int i = 0; i < 4; i++) reg_expect(addr_of(i));
    end
    report_test("lock", base);

    base = errors;
    apply_reset();
    reg_write(pmp_pkg::ADDR_MSECCFG, 32'h4);
    reg_expect(pmp_pkg::ADDR_MSECCFG);
    reg_write(pmp_pkg::ADDR_PMPCFG0, 32'h00000081);
    repeat (4) begin
      reg_write(pmp_pkg::ADDR_PMPCFG0, rand32() | 32'h80);
      reg_write(addr_of(0), rand32());
      reg_expect(pmp_pkg::ADDR_PMPCFG0);
      reg_expect(addr_of(0));
    end
    // Clearing always works, setting again is refused while locked
    reg_write(pmp_pkg::ADDR_MSECCFG, 32'h0);
    reg_write(pmp_pkg::ADDR_MSECCFG, 32'h4);
    reg_expect(pmp_pkg::ADDR_MSECCFG);
    reg_write(pmp_pkg::ADDR_PMPCFG0, rand32());
    reg_expect(pmp_pkg::ADDR_PMPCFG0);
    report_test("rlb", base);

    // RLB keeps every entry writable across rounds
    base = errors;
    apply_reset();
    reg_write(pmp_pkg::ADDR_MSECCFG, 32'h4);
    repeat (10) begin
      for (int i = 0; i < 4; i++) reg_write(addr_of(i), rand32());
      reg_write(pmp_pkg::ADDR_PMPCFG0, rand32());
      repeat (8) begin
        r = rand32();
        a = {m_addr[r[1:0]][29:0], 2'b00} + (rand32() & 32'h7f) - 32'h40;
        if (r[2]) a = rand32();
        check_access(a, 2'(r[9:8] % 3), r[12]);
      end
    end
    report_test("access", base);

    base = errors;
    apply_reset();
    repeat (8) begin
      r = rand32();
      check_access(rand32(), 2'(r[9:8] % 3), r[12]);
    end
    repeat (8) begin
      r = rand32();
      if (!is_mapped(r[7:0])) begin
        reg_write(r[7:0], rand32());
        reg_expect(r[7:0]);
      end
    end
    reg_expect(pmp_pkg::ADDR_PMPCFG0);
    reg_expect(pmp_pkg::ADDR_MSECCFG);
    report_test("defaults", base);

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- project.f
verilog/pmp_pkg.sv
verilog/pmp_region_match.sv
verilog/pmp_cfg_legalize.sv
verilog/pmp_check_fsm.sv
verilog/pmp_csr_regs.sv
verilog/pmp_csr_bus.sv
verilog/pmp_top.sv
test/pmp_props.sv
test/tb_pmp.sv

//--- Bender.yml
package:
  name: pmp

sources:
  - verilog/pmp_pkg.sv
  - verilog/pmp_region_match.sv
  - verilog/pmp_cfg_legalize.sv
  - verilog/pmp_check_fsm.sv
  - verilog/pmp_csr_regs.sv
  - verilog/pmp_csr_bus.sv
  - verilog/pmp_top.sv
  - target: test
    files:
      - test/pmp_props.sv
      - test/tb_pmp.sv
